// ==== dv/host_polling_tb.sv ====
module host_polling_tb
    import polling_pkg::*;
();

    // ==========================================================
    // Run length
    // ==========================================================
    localparam int RESET_CYCLES = 5;
    localparam int STIM_CYCLES  = 400;
    localparam int DRAIN_CYCLES = 12;
    localparam int MAX_CYCLES   = 2 * STIM_CYCLES + NUM_ENTRIES;

    // Falling edge that drives a response to the falling edge that sees its forward
    localparam int FWD_DELAY = 3;

    logic              clk;
    logic              reset;
    logic              start;
    logic [FLOW_W-1:0] last_flow;
    logic [ADDR_W-1:0] base_addr;
    logic              initialize;
    logic              initialized;
    poll_req_t         poll_req;
    logic              poll_req_valid;
    logic              req_almost_full;
    poll_rsp_t         poll_rsp;
    logic              rsp_valid;
    rpc_out_t          rpc_out;
    logic              rpc_out_valid;

    logic [31:0]            rng_state;
    int                     cycle;
    int                     value_errors;
    int                     other_errors;
    int                     req_count;
    int                     fwd_count;
    int                     sweep_cycles;
    logic                   init_done;

    // Reference model state
    logic [NUM_ENTRIES-1:0] model_flags;
    rpc_out_t               exp_rpc_q [$];
    int                     exp_due_q [$];
    int                     exp_flow;
    int                     exp_queue;
    int                     last_req_cycle;
    poll_rsp_t              last_rsp;
    logic                   last_counted;

    host_polling_top i_host_polling_top (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .last_flow       (last_flow),
        .base_addr       (base_addr),
        .initialize      (initialize),
        .initialized     (initialized),
        .poll_req        (poll_req),
        .poll_req_valid  (poll_req_valid),
        .req_almost_full (req_almost_full),
        .poll_rsp        (poll_rsp),
        .rsp_valid       (rsp_valid),
        .rpc_out         (rpc_out),
        .rpc_out_valid   (rpc_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog and cycle count for forward timing
    initial begin
        cycle = 0;
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("ERROR: timeout, run did not finish within %0d cycles", MAX_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // ==========================================================
    // Compare tasks
    // ==========================================================
    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s actual=%b expected=%b",
                     $time, name, actual, expected);
        end
    endtask

    task automatic check_poll_req(input string name, input poll_req_t actual,
                                  input poll_req_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s actual addr=%h tag=%0d expected addr=%h tag=%0d",
                     $time, name, actual.addr, actual.tag, expected.addr, expected.tag);
        end
    endtask

    // Fields shown as flow/entry/payload
    task automatic check_rpc_out(input string name, input rpc_out_t actual,
                                 input rpc_out_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s actual=%0d/%0d/%h expected=%0d/%0d/%h",
                     $time, name, actual.flow, actual.queue_entry, actual.payload,
                     expected.flow, expected.queue_entry, expected.payload);
        end
    endtask

    // ==========================================================
    // Reference model
    // ==========================================================
    task automatic predict_line(input poll_rsp_t rsp);
        int       idx;
        rpc_out_t exp;
        idx = (int'(rsp.tag) + int'(rsp.line_num)) % NUM_ENTRIES;
        if (rsp.line.update_flag != model_flags[ENTRY_W'(idx)]) begin
            model_flags[ENTRY_W'(idx)] = rsp.line.update_flag;
            exp.flow          = FLOW_W'(idx / QUEUE_DEPTH);
            exp.queue_entry   = QUEUE_W'(idx % QUEUE_DEPTH);
            exp.payload       = rsp.line.payload;
            exp_rpc_q.push_back(exp);
            exp_due_q.push_back(cycle + FWD_DELAY);
        end
    endtask

    // Inputs still hold the values seen at the last rising edge
    task automatic monitor_requests();
        poll_req_t exp;
        int        entry_idx;
        if (poll_req_valid) begin
            if (req_almost_full) begin
                other_errors++;
                $display("ERROR at %0t: poll request issued while req_almost_full was high",
                         $time);
            end
            if (!start) begin
                other_errors++;
                $display("ERROR at %0t: poll request issued while start was low", $time);
            end
            if (req_count > 0 && cycle - last_req_cycle < POLL_GAP + 2) begin
                other_errors++;
                $display("ERROR at %0t: poll requests only %0d cycles apart",
                         $time, cycle - last_req_cycle);
            end
            entry_idx = exp_flow * QUEUE_DEPTH + exp_queue;
            exp.addr  = base_addr + ADDR_W'(entry_idx);
            exp.tag   = ENTRY_W'(entry_idx);
            check_poll_req("poll_req", poll_req, exp);

            // Walk rule for the next request
            exp_queue = exp_queue + POLL_BATCH;
            if (exp_queue >= QUEUE_DEPTH) begin
                exp_queue = 0;
                exp_flow  = (exp_flow == int'(last_flow)) ? 0 : exp_flow + 1;
            end
            req_count++;
            last_req_cycle = cycle;
        end
    endtask

    task automatic monitor_forwards();
        if (exp_due_q.size() > 0 && exp_due_q[0] == cycle) begin
            check_flag("rpc_out_valid", rpc_out_valid, 1'b1);
            if (rpc_out_valid) begin
                check_rpc_out("rpc_out", rpc_out, exp_rpc_q[0]);
                fwd_count++;
            end
            void'(exp_rpc_q.pop_front());
            void'(exp_due_q.pop_front());
        end else begin
            check_flag("rpc_out_valid", rpc_out_valid, 1'b0);
        end
    endtask

    task automatic monitor_outputs();
        if (init_done) begin
            check_flag("initialized", initialized, 1'b1);
        end
        monitor_requests();
        monitor_forwards();
    endtask

    // ==========================================================
    // Stimulus
    // ==========================================================
    task automatic drive_inputs();
        logic [31:0] r;
        int          tag_val;
        r = next_random();
        req_almost_full = (r[5:4] == 2'b11);

        if (last_counted && r[9:8] == 2'b00) begin
            // Same entry and flag again on the next cycle
            start                 = 1'b1;
            poll_rsp              = last_rsp;
            poll_rsp.line.payload = next_random();
            rsp_valid             = 1'b1;
        end else begin
            start                     = (r[2:0] != 3'd0);
            tag_val                   = int'(r[17:10]) % NUM_ENTRIES;
            tag_val                   = tag_val - (tag_val % POLL_BATCH);
            poll_rsp.tag              = ENTRY_W'(tag_val);
            poll_rsp.line_num         = LINE_NUM_W'(int'(r[19:18]) % POLL_BATCH);
            poll_rsp.line.valid       = (r[21:20] != 2'b00);
            poll_rsp.line.update_flag = r[22];
            poll_rsp.line.payload     = next_random();
            rsp_valid                 = (r[25:24] != 2'b00);
        end

        last_counted = rsp_valid && poll_rsp.line.valid && start;
        if (last_counted) begin
            predict_line(poll_rsp);
        end
        last_rsp = poll_rsp;
    endtask

    initial begin
        rng_state       = 32'd11735;
        value_errors    = 0;
        other_errors    = 0;
        req_count       = 0;
        fwd_count       = 0;
        init_done       = 1'b0;
        model_flags     = '0;
        exp_flow        = 0;
        exp_queue       = 0;
        last_req_cycle  = 0;
        last_counted    = 1'b0;
        last_rsp        = '0;

        reset           = 1'b1;
        start           = 1'b0;
        last_flow       = FLOW_W'(2);
        base_addr       = ADDR_W'(next_random());
        initialize      = 1'b0;
        req_almost_full = 1'b0;
        poll_rsp        = '0;
        rsp_valid       = 1'b0;

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_flag("poll_req_valid", poll_req_valid, 1'b0);
        check_flag("rpc_out_valid", rpc_out_valid, 1'b0);
        check_flag("initialized", initialized, 1'b0);

        // Clearing sweep takes one cycle per entry
        initialize = 1'b1;
        @(negedge clk);
        initialize = 1'b0;
        sweep_cycles = 0;
        while (initialized !== 1'b1) begin
            @(negedge clk);
            sweep_cycles++;
        end
        if (sweep_cycles != NUM_ENTRIES) begin
            other_errors++;
            $display("ERROR at %0t: flag table sweep took %0d cycles instead of %0d",
                     $time, sweep_cycles, NUM_ENTRIES);
        end
        init_done   = 1'b1;
        model_flags = '0;

        repeat (STIM_CYCLES) begin
            monitor_outputs();
            drive_inputs();
            @(negedge clk);
        end

        // Let the pipeline empty
        monitor_outputs();
        start     = 1'b0;
        rsp_valid = 1'b0;
        @(negedge clk);
        repeat (DRAIN_CYCLES) begin
            monitor_outputs();
            @(negedge clk);
        end

        if (exp_rpc_q.size() != 0) begin
            other_errors++;
            $display("ERROR: %0d expected forwards never appeared", exp_rpc_q.size());
        end
        if (req_count == 0) begin
            other_errors++;
            $display("ERROR: no poll request was issued during the run");
        end

        $display("Summary: %0d value errors, %0d other errors, %0d poll requests, %0d forwards",
                 value_errors, other_errors, req_count, fwd_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the host polling testbench with Verilator

verilator --binary --timing --top-module host_polling_tb -f vlog.f \
    -Mdir obj_dir -o host_polling_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/host_polling_sim > sim.log 2>&1

grep -q '^\*\* PASS \*\*$' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== source/flag_table.sv ====
module flag_table
    import polling_pkg::*;
(
    input  logic               clk,
    input  logic               reset,

    // Clearing sweep control
    input  logic               initialize,
    output logic               initialized,

    // Lookup port, data one cycle after the address
    input  logic [ENTRY_W-1:0] rd_entry,
    output logic               rd_flag,

    // Update port
    input  logic               wr_en,
    input  logic [ENTRY_W-1:0] wr_entry,
    input  logic               wr_flag
);

    typedef enum logic {
        ST_IDLE,
        ST_SWEEP
    } sweep_state_t;

    sweep_state_t       state;
    logic [ENTRY_W-1:0] sweep_addr;
    logic               sweeping;

    // Expected update flag per entry
    logic               flags [NUM_ENTRIES];

    logic               mem_we;
    logic [ENTRY_W-1:0] mem_waddr;
    logic               mem_wdata;

    assign sweeping = (state == ST_SWEEP);

    // Sweep owns the write port while it runs
    assign mem_we    = sweeping || wr_en;
    assign mem_waddr = sweeping ? sweep_addr : wr_entry;
    assign mem_wdata = sweeping ? 1'b0 : wr_flag;

    // ==========================================================
    // Clearing sweep
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            sweep_addr  <= '0;
            initialized <= 1'b0;
        end else begin
            if (state == ST_IDLE && !initialized && initialize) begin
                state <= ST_SWEEP;
            end

            if (sweeping) begin
                if (sweep_addr == ENTRY_W'(NUM_ENTRIES - 1)) begin
                    state       <= ST_IDLE;
                    initialized <= 1'b1;
                end else begin
                    sweep_addr <= sweep_addr + 1'b1;
                end
            end
        end
    end

    // Storage, read returns the value held before this edge's write
    always_ff @(posedge clk) begin
        if (mem_we) begin
            flags[mem_waddr] <= mem_wdata;
        end
        rd_flag <= flags[rd_entry];
    end

endmodule

// ==== source/host_polling_top.sv ====
module host_polling_top
    import polling_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // Control and status
    input  logic              start,
    input  logic [FLOW_W-1:0] last_flow,
    input  logic [ADDR_W-1:0] base_addr,
    input  logic              initialize,
    output logic              initialized,

    // Host read requests
    output poll_req_t         poll_req,
    output logic              poll_req_valid,
    input  logic              req_almost_full,

    // Host read responses
    input  poll_rsp_t         poll_rsp,
    input  logic              rsp_valid,

    // Forwarded RPCs
    output rpc_out_t          rpc_out,
    output logic              rpc_out_valid
);

    polled_entry_t      entry;
    logic               entry_valid;
    logic [ENTRY_W-1:0] rd_entry;
    logic               rd_flag;
    logic               wr_en;
    logic [ENTRY_W-1:0] wr_entry;
    logic               wr_flag;

    // ==========================================================
    // Request side
    // ==========================================================
    poll_issuer i_poll_issuer (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .last_flow       (last_flow),
        .base_addr       (base_addr),
        .req_almost_full (req_almost_full),
        .poll_req        (poll_req),
        .poll_req_valid  (poll_req_valid)
    );

    // ==========================================================
    // Response side
    // ==========================================================
    response_decoder i_response_decoder (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .poll_rsp    (poll_rsp),
        .rsp_valid   (rsp_valid),
        .entry       (entry),
        .entry_valid (entry_valid)
    );

    update_detector i_update_detector (
        .clk           (clk),
        .reset         (reset),
        .entry         (entry),
        .entry_valid   (entry_valid),
        .rd_entry      (rd_entry),
        .rd_flag       (rd_flag),
        .wr_en         (wr_en),
        .wr_entry      (wr_entry),
        .wr_flag       (wr_flag),
        .rpc_out       (rpc_out),
        .rpc_out_valid (rpc_out_valid)
    );

    flag_table i_flag_table (
        .clk         (clk),
        .reset       (reset),
        .initialize  (initialize),
        .initialized (initialized),
        .rd_entry    (rd_entry),
        .rd_flag     (rd_flag),
        .wr_en       (wr_en),
        .wr_entry    (wr_entry),
        .wr_flag     (wr_flag)
    );

endmodule

// ==== source/poll_issuer.sv ====
module poll_issuer
    import polling_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // Control
    input  logic              start,
    input  logic [FLOW_W-1:0] last_flow,
    input  logic [ADDR_W-1:0] base_addr,

    // Host read channel
    input  logic              req_almost_full,
    output poll_req_t         poll_req,
    output logic              poll_req_valid
);

    typedef enum logic {
        ST_IDLE,
        ST_GAP
    } issuer_state_t;

    issuer_state_t        state;
    logic [GAP_CNT_W-1:0] gap_cnt;
    logic [QUEUE_W-1:0]   queue_cnt;
    logic [FLOW_W-1:0]    flow_cnt;
    logic [ENTRY_W-1:0]   cur_entry;
    logic                 fire;

    // Entry index of the first line in the batch
    assign cur_entry = {flow_cnt, queue_cnt};

    // Back-pressure only matters when a new request could go out
    assign fire = (state == ST_IDLE) && start && !req_almost_full;

    // ==========================================================
    // Pacing FSM and walk counters
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= ST_IDLE;
            gap_cnt        <= '0;
            queue_cnt      <= '0;
            flow_cnt       <= '0;
            poll_req_valid <= 1'b0;
        end else begin
            poll_req_valid <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (fire) begin
                        poll_req_valid <= 1'b1;
                        state          <= ST_GAP;

                        // Step to the next batch, then to the next flow
                        if (queue_cnt == QUEUE_W'(QUEUE_DEPTH - POLL_BATCH)) begin
                            queue_cnt <= '0;
                            if (flow_cnt >= last_flow) begin
                                flow_cnt <= '0;
                            end else begin
                                flow_cnt <= flow_cnt + 1'b1;
                            end
                        end else begin
                            queue_cnt <= queue_cnt + QUEUE_W'(POLL_BATCH);
                        end
                    end
                end

                ST_GAP: begin
                    // The request cycle counts as gap step zero
                    if (gap_cnt == GAP_CNT_W'(POLL_GAP)) begin
                        gap_cnt <= '0;
                        state   <= ST_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request payload, built from the counters before they step
    always_ff @(posedge clk) begin
        if (fire) begin
            poll_req.addr <= base_addr + ADDR_W'(cur_entry);
            poll_req.tag  <= cur_entry;
        end
    end

endmodule

// ==== source/polling_pkg.sv ====
package polling_pkg;

    // ==========================================================
    // Queue geometry
    // ==========================================================

    // Flows and entries per flow queue
    localparam int FLOW_W      = 2;
    localparam int QUEUE_W     = 3;
    localparam int QUEUE_DEPTH = 2 ** QUEUE_W;

    // Flat entry index is {flow, queue entry}
    localparam int ENTRY_W     = FLOW_W + QUEUE_W;
    localparam int NUM_ENTRIES = 2 ** ENTRY_W;

    // ==========================================================
    // Polling pace and host bus widths
    // ==========================================================

    // Lines returned by one read request
    localparam int POLL_BATCH = 4;
    localparam int LINE_NUM_W = 2;

    // Idle cycles after each request, plus the counter that paces them
    localparam int POLL_GAP  = 3;
    localparam int GAP_CNT_W = $clog2(POLL_GAP + 1);

    localparam int ADDR_W    = 16;
    localparam int PAYLOAD_W = 32;

    // ==========================================================
    // Bus types
    // ==========================================================

    // Host read request, tag is the entry index of the first line
    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [ENTRY_W-1:0] tag;
    } poll_req_t;

    // One polled host line
    typedef struct packed {
        logic                 valid;
        logic                 update_flag;
        logic [PAYLOAD_W-1:0] payload;
    } rpc_line_t;

    // Read response, one line per beat
    typedef struct packed {
        logic [ENTRY_W-1:0]    tag;
        logic [LINE_NUM_W-1:0] line_num;
        rpc_line_t             line;
    } poll_rsp_t;

    // Decoded line heading to the update detector
    typedef struct packed {
        logic [ENTRY_W-1:0]   index;
        logic                 update_flag;
        logic [PAYLOAD_W-1:0] payload;
    } polled_entry_t;

    // Forwarded RPC
    typedef struct packed {
        logic [FLOW_W-1:0]    flow;
        logic [QUEUE_W-1:0]   queue_entry;
        logic [PAYLOAD_W-1:0] payload;
    } rpc_out_t;

endpackage

// ==== source/response_decoder.sv ====
module response_decoder
    import polling_pkg::*;
(
    input  logic          clk,
    input  logic          reset,

    // Polling enabled
    input  logic          start,

    // Host read responses
    input  poll_rsp_t     poll_rsp,
    input  logic          rsp_valid,

    // Decoded line to the update detector
    output polled_entry_t entry,
    output logic          entry_valid
);

    logic [ENTRY_W-1:0] line_index;
    logic               keep_line;

    // Tag names the first line of the batch, line_num picks the one inside it
    assign line_index = poll_rsp.tag + ENTRY_W'(poll_rsp.line_num);

    // Lines with the valid bit clear never reach the flag table
    assign keep_line = start && rsp_valid && poll_rsp.line.valid;

    // ==========================================================
    // Response register
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= 1'b0;
        end else begin
            entry_valid <= keep_line;
        end
    end

    // Line contents, qualified by entry_valid downstream
    always_ff @(posedge clk) begin
        entry.index       <= line_index;
        entry.update_flag <= poll_rsp.line.update_flag;
        entry.payload     <= poll_rsp.line.payload;
    end

endmodule

// ==== source/update_detector.sv ====
module update_detector
    import polling_pkg::*;
(
    input  logic               clk,
    input  logic               reset,

    // Decoded line from the response decoder
    input  polled_entry_t      entry,
    input  logic               entry_valid,

    // Flag table lookup
    output logic [ENTRY_W-1:0] rd_entry,
    input  logic               rd_flag,

    // Flag table update
    output logic               wr_en,
    output logic [ENTRY_W-1:0] wr_entry,
    output logic               wr_flag,

    // Forwarded RPC
    output rpc_out_t           rpc_out,
    output logic               rpc_out_valid
);

    // Line held while the table read completes
    polled_entry_t      held;
    logic               held_valid;

    // Write committed at the last edge, missed by the read at that edge
    logic               wr_en_d;
    logic [ENTRY_W-1:0] wr_entry_d;
    logic               wr_flag_d;

    logic               stored_flag;
    logic               is_new;

    // Lookup starts as soon as the decoder presents the line
    assign rd_entry = entry.index;

    // ==========================================================
    // Stored flag with write bypass
    // ==========================================================
    always_comb begin
        stored_flag = rd_flag;

        if (wr_en_d && wr_entry_d == held.index) begin
            stored_flag = wr_flag_d;
        end

        // Pending write is newer and wins
        if (wr_en && wr_entry == held.index) begin
            stored_flag = wr_flag;
        end

        is_new = held_valid && (held.update_flag != stored_flag);
    end

    // Control
    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid    <= 1'b0;
            wr_en         <= 1'b0;
            wr_en_d       <= 1'b0;
            rpc_out_valid <= 1'b0;
        end else begin
            held_valid    <= entry_valid;
            wr_en         <= is_new;
            wr_en_d       <= wr_en;
            rpc_out_valid <= is_new;
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        held <= entry;

        // New flag value becomes the expected one
        wr_entry   <= held.index;
        wr_flag    <= held.update_flag;
        wr_entry_d <= wr_entry;
        wr_flag_d  <= wr_flag;

        // Split the flat index back into flow and queue entry
        rpc_out.flow        <= held.index[ENTRY_W-1:QUEUE_W];
        rpc_out.queue_entry <= held.index[QUEUE_W-1:0];
        rpc_out.payload     <= held.payload;
    end

endmodule

// ==== vlog.f ====
source/polling_pkg.sv
source/poll_issuer.sv
source/response_decoder.sv
source/flag_table.sv
source/update_detector.sv
source/host_polling_top.sv
dv/host_polling_tb.sv
